/* rtl/scene_macros.svh */
`ifndef SCENE_MACROS_SVH
`define SCENE_MACROS_SVH

// three 16-bit fixed-point coordinates
`define SCENE_VTX_W    48
// three 8-bit local vertex indices
`define SCENE_TRI_W    24

`define SCENE_DEPTH    256
`define SCENE_ADDR_W   8
`define SCENE_BUF_IDS  16
`define SCENE_ID_W     4

`endif

/* rtl/scene_pkg.sv */
`include "scene_macros.svh"

package scene_pkg;

    typedef logic [`SCENE_VTX_W-1:0]  vertex_t;
    typedef logic [`SCENE_TRI_W-1:0]  tri_t;
    typedef logic [`SCENE_ADDR_W-1:0] addr_t;
    typedef logic [7:0]               count_t;  // element count or local index
    typedef logic [`SCENE_ID_W-1:0]   buf_id_t;

    typedef logic [1:0] opcode_t;
    localparam opcode_t OP_WIPE     = 2'd0;
    localparam opcode_t OP_NEW_VERT = 2'd1;
    localparam opcode_t OP_NEW_TRI  = 2'd2;
    localparam opcode_t OP_BAD      = 2'd3;  // reserved, rejected

    typedef logic [1:0] status_t;
    localparam status_t ST_OK        = 2'd0;
    localparam status_t ST_OVERFLOW  = 2'd1;
    localparam status_t ST_BAD_OP    = 2'd2;
    localparam status_t ST_BAD_INDEX = 2'd3;

    typedef enum logic [1:0] {C_IDLE, C_VERT_DATA, C_TRI_DATA, C_RESPOND} cmd_state_t;

    typedef enum logic [1:0] {F_IDLE, F_TRI_RD, F_V_RD, F_DONE} fetch_state_t;

endpackage

/* rtl/store_wr_if.sv */
`timescale 1ns/1ns

interface store_wr_if;
    import scene_pkg::*;

    logic    clear;       // drop every descriptor
    logic    desc_we;
    buf_id_t desc_id;
    addr_t   desc_base;
    count_t  desc_count;
    logic    data_we;
    addr_t   data_addr;
    vertex_t data;        // triangle store keeps the low bits

    modport ctrl (
        output clear, desc_we, desc_id, desc_base, desc_count,
        output data_we, data_addr, data
    );

    modport store (
        input clear, desc_we, desc_id, desc_base, desc_count,
        input data_we, data_addr, data
    );
endinterface

/* rtl/store_rd_if.sv */
`timescale 1ns/1ns

interface store_rd_if;
    import scene_pkg::*;

    logic    rd_en;
    buf_id_t rd_id;
    count_t  rd_index;    // local index inside the buffer
    vertex_t rd_data;     // zero when rd_ok is low
    logic    rd_ok;

    // store answers one cycle after rd_en
    modport fetch (
        output rd_en, rd_id, rd_index,
        input  rd_data, rd_ok
    );

    modport store (
        input  rd_en, rd_id, rd_index,
        output rd_data, rd_ok
    );

endinterface

/* rtl/scene_cmd_ctrl.sv */
`timescale 1ns/1ns
`include "scene_macros.svh"

module scene_cmd_ctrl (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  scene_pkg::opcode_t      cmd_op,
    input  logic [`SCENE_VTX_W-1:0] cmd_data,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output scene_pkg::status_t      rsp_status,
    output scene_pkg::buf_id_t      rsp_id,
    store_wr_if.ctrl                vwr,
    store_wr_if.ctrl                twr
);
    import scene_pkg::*;

    cmd_state_t             state;
    logic [`SCENE_ID_W:0]   next_vid;     // one extra bit to see id 16
    logic [`SCENE_ID_W:0]   next_tid;
    logic [`SCENE_ADDR_W:0] next_vaddr;   // may reach 256
    logic [`SCENE_ADDR_W:0] next_taddr;
    count_t                 remaining;    // data words still expected
    addr_t                  wr_addr;
    logic                   wr_ok;        // allocation of current buffer passed

    logic                   accept;
    logic                   hdr_accept;
    logic                   wipe;
    logic                   is_tri;
    logic                   alloc_ok;
    count_t                 hdr_count;
    logic [`SCENE_ID_W:0]   sel_id;
    logic [`SCENE_ADDR_W:0] sel_addr;
    logic [`SCENE_ADDR_W:0] sel_end;

    assign cmd_ready  = (state != C_RESPOND);
    assign rsp_valid  = (state == C_RESPOND);
    assign accept     = cmd_valid && cmd_ready;
    assign hdr_accept = accept && (state == C_IDLE);
    assign wipe       = hdr_accept && (cmd_op == OP_WIPE);
    assign hdr_count  = cmd_data[7:0];

    // allocator of the store named by the opcode
    assign is_tri   = (cmd_op == OP_NEW_TRI);
    assign sel_id   = is_tri ? next_tid : next_vid;
    assign sel_addr = is_tri ? next_taddr : next_vaddr;
    assign sel_end  = sel_addr + {1'b0, hdr_count};
    assign alloc_ok = !sel_id[`SCENE_ID_W] && (sel_end <= `SCENE_DEPTH);

    assign vwr.clear      = wipe;
    assign vwr.desc_we    = hdr_accept && (cmd_op == OP_NEW_VERT) && alloc_ok;
    assign vwr.desc_id    = sel_id[`SCENE_ID_W-1:0];
    assign vwr.desc_base  = sel_addr[`SCENE_ADDR_W-1:0];
    assign vwr.desc_count = hdr_count;
    assign vwr.data_we    = accept && (state == C_VERT_DATA) && wr_ok;
    assign vwr.data_addr  = wr_addr;
    assign vwr.data       = cmd_data;

    assign twr.clear      = wipe;
    assign twr.desc_we    = hdr_accept && is_tri && alloc_ok;
    assign twr.desc_id    = sel_id[`SCENE_ID_W-1:0];
    assign twr.desc_base  = sel_addr[`SCENE_ADDR_W-1:0];
    assign twr.desc_count = hdr_count;
    assign twr.data_we    = accept && (state == C_TRI_DATA) && wr_ok;
    assign twr.data_addr  = wr_addr;
    assign twr.data       = cmd_data;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state      <= C_IDLE;
            next_vid   <= '0;
            next_tid   <= '0;
            next_vaddr <= '0;
            next_taddr <= '0;
            remaining  <= '0;
            wr_ok      <= 1'b0;
        end else begin
            case (state)
                C_IDLE: if (accept) begin
                    case (cmd_op)
                        OP_WIPE: begin
                            next_vid   <= '0;
                            next_tid   <= '0;
                            next_vaddr <= '0;
                            next_taddr <= '0;
                            state      <= C_RESPOND;
                        end
                        OP_NEW_VERT, OP_NEW_TRI: begin
                            if (alloc_ok && is_tri) begin
                                next_tid   <= next_tid + 1'b1;
                                next_taddr <= sel_end;
                            end else if (alloc_ok) begin
                                next_vid   <= next_vid + 1'b1;
                                next_vaddr <= sel_end;
                            end
                            wr_ok     <= alloc_ok;  // overflow still eats the data
                            remaining <= hdr_count;
                            if (hdr_count == '0) begin
                                state <= C_RESPOND;
                            end else if (is_tri) begin
                                state <= C_TRI_DATA;
                            end else begin
                                state <= C_VERT_DATA;
                            end
                        end
                        default: state <= C_RESPOND;
                    endcase
                end
                C_VERT_DATA, C_TRI_DATA: if (accept) begin
                    remaining <= remaining - 1'b1;
                    if (remaining == 8'd1) begin
                        state <= C_RESPOND;
                    end
                end
                C_RESPOND: if (rsp_ready) begin
                    state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // write pointer and response payload
    always_ff @(posedge sck) begin
        if (hdr_accept) begin
            wr_addr <= sel_addr[`SCENE_ADDR_W-1:0];
            case (cmd_op)
                OP_WIPE: begin
                    rsp_status <= ST_OK;
                    rsp_id     <= '0;
                end
                OP_NEW_VERT, OP_NEW_TRI: begin
                    rsp_status <= alloc_ok ? ST_OK : ST_OVERFLOW;
                    rsp_id     <= alloc_ok ? sel_id[`SCENE_ID_W-1:0] : '0;
                end
                default: begin
                    rsp_status <= ST_BAD_OP;
                    rsp_id     <= '0;
                end
            endcase
        end else if (accept) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

/* rtl/buf_store.sv */
`timescale 1ns/1ns
`include "scene_macros.svh"

module buf_store #(
    parameter int DATA_W = 48
) (
    input  logic      sck,
    input  logic      rst,
    store_wr_if.store wr,
    store_rd_if.store rd
);
    import scene_pkg::*;

    addr_t                     desc_base  [`SCENE_BUF_IDS];
    count_t                    desc_count [`SCENE_BUF_IDS];
    logic [`SCENE_BUF_IDS-1:0] desc_valid;

    logic [DATA_W-1:0] ram [`SCENE_DEPTH];

    addr_t             rd_addr;
    logic              hit;
    logic [DATA_W-1:0] rd_q;
    logic              rd_ok_q;
    vertex_t           rd_ext;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            desc_valid <= '0;
        end else if (wr.clear) begin
            desc_valid <= '0;
        end else if (wr.desc_we) begin
            desc_valid[wr.desc_id] <= 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (wr.desc_we) begin
            desc_base[wr.desc_id]  <= wr.desc_base;
            desc_count[wr.desc_id] <= wr.desc_count;
        end
    end

    always_ff @(posedge sck) begin
        if (wr.data_we) begin
            ram[wr.data_addr] <= wr.data[DATA_W-1:0];
        end
    end

    // local index to RAM address, plus bounds check
    assign rd_addr = desc_base[rd.rd_id] + rd.rd_index;
    assign hit     = desc_valid[rd.rd_id] && (rd.rd_index < desc_count[rd.rd_id]);

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            rd_ok_q <= 1'b0;
        end else begin
            rd_ok_q <= rd.rd_en && hit;
        end
    end

    always_ff @(posedge sck) begin
        if (rd.rd_en) begin
            rd_q <= ram[rd_addr];
        end
    end

    always_comb begin
        rd_ext              = '0;
        rd_ext[DATA_W-1:0] = rd_q;  // zero extend for the triangle store
    end

    assign rd.rd_data = rd_ok_q ? rd_ext : '0;
    assign rd.rd_ok   = rd_ok_q;

endmodule

/* rtl/prim_fetch.sv */
`timescale 1ns/1ns
`include "scene_macros.svh"

module prim_fetch (
    input  logic                sck,
    input  logic                rst,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    input  scene_pkg::buf_id_t  fetch_vbuf,
    input  scene_pkg::buf_id_t  fetch_tbuf,
    input  scene_pkg::count_t   fetch_tri,
    output logic                prim_valid,
    input  logic                prim_ready,
    output scene_pkg::status_t  prim_status,
    output scene_pkg::vertex_t  prim_v0,
    output scene_pkg::vertex_t  prim_v1,
    output scene_pkg::vertex_t  prim_v2,
    store_rd_if.fetch           trd,
    store_rd_if.fetch           vrd
);
    import scene_pkg::*;

    fetch_state_t state;
    logic [1:0]   vk;      // vertex whose read data arrives this cycle
    logic         bad;     // any read of this request failed
    buf_id_t      vbuf_q;
    tri_t         tri_q;
    vertex_t      v0_q;
    vertex_t      v1_q;
    vertex_t      v2_q;
    logic         accept;

    assign fetch_ready = (state == F_IDLE);
    assign accept      = fetch_valid && fetch_ready;

    // triangle read goes out with the request
    assign trd.rd_en    = accept;
    assign trd.rd_id    = fetch_tbuf;
    assign trd.rd_index = fetch_tri;

    // vertex 0 straight from the triangle data, 1 and 2 from the latched copy
    assign vrd.rd_en = (state == F_TRI_RD) || ((state == F_V_RD) && (vk != 2'd2));
    assign vrd.rd_id = vbuf_q;

    always_comb begin
        if (state == F_TRI_RD) begin
            vrd.rd_index = trd.rd_data[7:0];
        end else if (vk == 2'd0) begin
            vrd.rd_index = tri_q[15:8];
        end else begin
            vrd.rd_index = tri_q[23:16];
        end
    end

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state <= F_IDLE;
            vk    <= '0;
            bad   <= 1'b0;
        end else begin
            case (state)
                F_IDLE: if (accept) begin
                    state <= F_TRI_RD;
                end
                F_TRI_RD: begin
                    bad   <= !trd.rd_ok;
                    vk    <= '0;
                    state <= F_V_RD;
                end
                F_V_RD: begin
                    if (!vrd.rd_ok) begin
                        bad <= 1'b1;
                    end
                    vk <= vk + 1'b1;
                    if (vk == 2'd2) begin
                        state <= F_DONE;
                    end
                end
                F_DONE: if (prim_ready) begin
                    state <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge sck) begin
        if (accept) begin
            vbuf_q <= fetch_vbuf;
        end
        if (state == F_TRI_RD) begin
            tri_q <= trd.rd_data[`SCENE_TRI_W-1:0];
        end
        if (state == F_V_RD) begin
            case (vk)
                2'd0:    v0_q <= vrd.rd_data;
                2'd1:    v1_q <= vrd.rd_data;
                default: v2_q <= vrd.rd_data;
            endcase
        end
    end

    assign prim_valid  = (state == F_DONE);
    assign prim_status = bad ? ST_BAD_INDEX : ST_OK;
    assign prim_v0     = bad ? '0 : v0_q;  // failed fetch returns zeros
    assign prim_v1     = bad ? '0 : v1_q;
    assign prim_v2     = bad ? '0 : v2_q;

endmodule

/* rtl/scene_mem_top.sv */
`timescale 1ns/1ns
`include "scene_macros.svh"

module scene_mem_top (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  scene_pkg::opcode_t      cmd_op,
    input  logic [`SCENE_VTX_W-1:0] cmd_data,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output scene_pkg::status_t      rsp_status,
    output scene_pkg::buf_id_t      rsp_id,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  scene_pkg::buf_id_t      fetch_vbuf,
    input  scene_pkg::buf_id_t      fetch_tbuf,
    input  scene_pkg::count_t       fetch_tri,
    output logic                    prim_valid,
    input  logic                    prim_ready,
    output scene_pkg::status_t      prim_status,
    output scene_pkg::vertex_t      prim_v0,
    output scene_pkg::vertex_t      prim_v1,
    output scene_pkg::vertex_t      prim_v2
);

    store_wr_if vwr_if ();
    store_wr_if twr_if ();
    store_rd_if vrd_if ();
    store_rd_if trd_if ();

    scene_cmd_ctrl cmd_ctrl_i (
        .sck        (sck),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_status (rsp_status),
        .rsp_id     (rsp_id),
        .vwr        (vwr_if.ctrl),
        .twr        (twr_if.ctrl)
    );

    buf_store #(.DATA_W(`SCENE_VTX_W)) vert_store (
        .sck (sck),
        .rst (rst),
        .wr  (vwr_if.store),
        .rd  (vrd_if.store)
    );

    buf_store #(.DATA_W(`SCENE_TRI_W)) tri_store (
        .sck (sck),
        .rst (rst),
        .wr  (twr_if.store),
        .rd  (trd_if.store)
    );

    prim_fetch fetch_i (
        .sck         (sck),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_vbuf  (fetch_vbuf),
        .fetch_tbuf  (fetch_tbuf),
        .fetch_tri   (fetch_tri),
        .prim_valid  (prim_valid),
        .prim_ready  (prim_ready),
        .prim_status (prim_status),
        .prim_v0     (prim_v0),
        .prim_v1     (prim_v1),
        .prim_v2     (prim_v2),
        .trd         (trd_if.fetch),
        .vrd         (vrd_if.fetch)
    );

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 4
) (
    output logic sck,
    output logic rst
);

    initial begin
        sck = 1'b0;
        forever #(PERIOD / 2) sck = ~sck;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge sck);
        #1 rst = 1'b0;  // released just after the edge
    end

endmodule

/* tb/scene_mem_asserts.sv */
`timescale 1ns/1ns

module scene_mem_asserts (
    input logic               sck,
    input logic               rst,
    input logic               cmd_ready,
    input logic               rsp_valid,
    input logic               rsp_ready,
    input scene_pkg::status_t rsp_status,
    input scene_pkg::buf_id_t rsp_id,
    input logic               prim_valid,
    input logic               prim_ready,
    input scene_pkg::status_t prim_status,
    input scene_pkg::vertex_t prim_v0,
    input scene_pkg::vertex_t prim_v1,
    input scene_pkg::vertex_t prim_v2
);

    rsp_held: assert property (@(posedge sck) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_status, rsp_id}))
        else $error("response changed while stalled");

    prim_held: assert property (@(posedge sck) disable iff (rst)
        prim_valid && !prim_ready |=>
            prim_valid && $stable({prim_status, prim_v0, prim_v1, prim_v2}))
        else $error("primitive changed while stalled");

    cmd_blocked: assert property (@(posedge sck) disable iff (rst)
        rsp_valid |-> !cmd_ready)
        else $error("command accepted with a response pending");

    // first edge after reset release
    reset_quiet: assert property (@(posedge sck)
        $fell(rst) |-> !rsp_valid && !prim_valid)
        else $error("valid high right after reset");

endmodule

bind scene_mem_top scene_mem_asserts asserts_i (
    .sck         (sck),
    .rst         (rst),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_status  (rsp_status),
    .rsp_id      (rsp_id),
    .prim_valid  (prim_valid),
    .prim_ready  (prim_ready),
    .prim_status (prim_status),
    .prim_v0     (prim_v0),
    .prim_v1     (prim_v1),
    .prim_v2     (prim_v2)
);

/* tb/scene_mem_tb.sv */
`timescale 1ns/1ns

module scene_mem_tb;
    import scene_pkg::*;

    localparam int TIMEOUT = 200;  // cycles per wait

    logic    sck;
    logic    rst;
    logic    cmd_valid;
    logic    cmd_ready;
    opcode_t cmd_op;
    vertex_t cmd_data;
    logic    rsp_valid;
    logic    rsp_ready;
    status_t rsp_status;
    buf_id_t rsp_id;
    logic    fetch_valid;
    logic    fetch_ready;
    buf_id_t fetch_vbuf;
    buf_id_t fetch_tbuf;
    count_t  fetch_tri;
    logic    prim_valid;
    logic    prim_ready;
    status_t prim_status;
    vertex_t prim_v0;
    vertex_t prim_v1;
    vertex_t prim_v2;

    logic [15:0] lfsr;
    int          tests;
    int          errors;
    logic        timed_out;

    clk_gen clk_gen_i (.sck(sck), .rst(rst));

    scene_mem_top scene_mem_top_i (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois with taps 16 14 13 11
    endfunction

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic send_cmd(input opcode_t op, input vertex_t data);
        int   waited;
        logic done;
        waited    = 0;
        done      = 1'b0;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_data  = data;
        while (!done && !timed_out) begin
            #3;
            done = cmd_ready;  // transfer on the coming edge
            @(posedge sck);
            #1;
            waited++;
            if (!done && waited > TIMEOUT) begin
                $display("timeout: command word %h was never accepted", data);
                timed_out = 1'b1;
            end
        end
        cmd_valid = 1'b0;
    endtask

    task automatic check_rsp(input status_t exp_st, input buf_id_t exp_id, input string name);
        int      waited;
        logic    got;
        logic    rdy;
        status_t st;
        buf_id_t id;
        waited = 0;
        got    = 1'b0;
        st     = '0;
        id     = '0;
        while (!got && !timed_out) begin
            random_bit(rdy);
            rsp_ready = rdy;
            #3;
            if (rsp_valid && rsp_ready) begin
                got = 1'b1;
                st  = rsp_status;
                id  = rsp_id;
            end
            @(posedge sck);
            #1;
            waited++;
            if (!got && waited > TIMEOUT) begin
                $display("timeout: %s never saw a response", name);
                timed_out = 1'b1;
            end
        end
        rsp_ready = 1'b0;
        if (got) begin
            tests++;
            if (st != exp_st || id != exp_id) begin
                errors++;
                $display("FAIL %s expected status %0d id %0d, actual status %0d id %0d",
                         name, exp_st, exp_id, st, id);
            end else begin
                $display("PASS %s status %0d id %0d", name, st, id);
            end
        end
    endtask

    task automatic run_fetch(input buf_id_t vbuf, input buf_id_t tbuf, input count_t tri_num,
                             input status_t exp_st, input vertex_t e0, input vertex_t e1,
                             input vertex_t e2, input string name);
        int      waited;
        logic    done;
        logic    rdy;
        status_t st;
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
        waited      = 0;
        done        = 1'b0;
        fetch_valid = 1'b1;
        fetch_vbuf  = vbuf;
        fetch_tbuf  = tbuf;
        fetch_tri   = tri_num;
        while (!done && !timed_out) begin
            #3;
            done = fetch_ready;
            @(posedge sck);
            #1;
            waited++;
            if (!done && waited > TIMEOUT) begin
                $display("timeout: %s request was never accepted", name);
                timed_out = 1'b1;
            end
        end
        fetch_valid = 1'b0;
        waited      = 0;
        done        = 1'b0;
        while (!done && !timed_out) begin
            random_bit(rdy);
            prim_ready = rdy;
            #3;
            if (prim_valid && prim_ready) begin
                done = 1'b1;
                st   = prim_status;
                v0   = prim_v0;
                v1   = prim_v1;
                v2   = prim_v2;
            end
            @(posedge sck);
            #1;
            waited++;
            if (!done && waited > TIMEOUT) begin
                $display("timeout: %s never returned a primitive", name);
                timed_out = 1'b1;
            end
        end
        prim_ready = 1'b0;
        if (done) begin
            tests++;
            if (st != exp_st || v0 != e0 || v1 != e1 || v2 != e2) begin
                errors++;
                $display("FAIL %s expected %0d %h %h %h, actual %0d %h %h %h",
                         name, exp_st, e0, e1, e2, st, v0, v1, v2);
            end else begin
                $display("PASS %s status %0d", name, st);
            end
        end
    endtask

    initial begin
        string      line;
        string      rest;
        byte        kind;
        int         fd;
        int         n;
        int         lineno;
        int         reps;
        int         k;
        int         waited;
        logic [7:0] p0;
        logic [7:0] p1;
        logic [7:0] p2;
        logic [7:0] p3;
        vertex_t    word;
        vertex_t    e0;
        vertex_t    e1;
        vertex_t    e2;

        cmd_valid   = 1'b0;
        cmd_op      = '0;
        cmd_data    = '0;
        rsp_ready   = 1'b0;
        fetch_valid = 1'b0;
        fetch_vbuf  = '0;
        fetch_tbuf  = '0;
        fetch_tri   = '0;
        prim_ready  = 1'b0;
        lfsr        = 16'd30543;
        tests       = 0;
        errors      = 0;
        timed_out   = 1'b0;

        waited = 0;
        do begin
            @(posedge sck);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: reset was never released");
                timed_out = 1'b1;
            end
        end while (rst && !timed_out);
        #1;

        fd = $fopen("tb/scene_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/scene_vectors.txt");
            errors++;
        end
        lineno = 0;
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            lineno++;
            if (n < 2 || line[0] == "#") begin
                continue;  // blank, comment or end of file
            end
            kind = line[0];
            rest = line.substr(1, line.len() - 1);
            if (kind == "C") begin
                reps = 1;  // optional third column repeats the word
                n    = $sscanf(rest, "%h %h %h", p0, word, reps);
                for (k = 0; k < reps && !timed_out; k++) begin
                    send_cmd(p0[1:0], word);
                end
            end else if (kind == "R") begin
                n = $sscanf(rest, "%h %h", p0, p1);
                check_rsp(p0[1:0], p1[3:0], $sformatf("rsp_line%0d", lineno));
            end else if (kind == "F") begin
                n = $sscanf(rest, "%h %h %h %h %h %h %h", p0, p1, p2, p3, e0, e1, e2);
                run_fetch(p0[3:0], p1[3:0], p2, p3[1:0], e0, e1, e2,
                          $sformatf("fetch_line%0d", lineno));
            end else begin
                $display("line %0d of the vector file has an unknown kind", lineno);
                errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests %0d, failures %0d, timeout %0d", tests, errors, timed_out);
        if (errors == 0 && !timed_out && tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/scene_pkg.sv
rtl/store_wr_if.sv
rtl/store_rd_if.sv
rtl/scene_cmd_ctrl.sv
rtl/buf_store.sv
rtl/prim_fetch.sv
rtl/scene_mem_top.sv
tb/clk_gen.sv
tb/scene_mem_asserts.sv
tb/scene_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the scene memory testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module scene_mem_tb -f flist.f -o scene_mem_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/scene_mem_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* tb/scene_vectors.txt */
# C op data [repeat] | R status id | F vbuf tbuf tri status v0 v1 v2
# all fields hex, data words of a create carry op 0
C 1 000000000004
C 0 000100020003
C 0 001000200030
C 0 010002000300
C 0 100020003000
R 0 0
C 1 000000000002
C 0 aaaa0000bbbb
C 0 cccc0000dddd
R 0 1
C 2 000000000003
C 0 000000000102
C 0 000000030200
C 0 000000040100
R 0 0
C 2 000000000001
C 0 000000000001
R 0 1
F 0 0 00 0 010002000300 001000200030 000100020003
F 0 0 01 0 000100020003 010002000300 100020003000
F 1 1 00 0 cccc0000dddd aaaa0000bbbb aaaa0000bbbb
F 0 0 02 3 0 0 0
F 0 0 03 3 0 0 0
F 1 0 00 3 0 0 0
F 0 5 00 3 0 0 0
F 7 0 00 3 0 0 0
C 1 0000000000fb
C 0 5a5a5a5a5a5a fb
R 1 0
C 1 000000000001
C 0 0000ffff0000
R 0 2
C 3 000000000000
R 2 0
C 0 000000000000
R 0 0
F 0 0 00 3 0 0 0
C 1 000000000001
C 0 123456789abc
R 0 0
C 2 000000000001
C 0 000000000000
R 0 0
F 0 0 00 0 123456789abc 123456789abc 123456789abc
